//--- files.f
verilog/i3c_target_pkg.sv
verilog/bus_monitor.sv
verilog/bus_rx_flow.sv
verilog/bus_tx_flow.sv
verilog/bus_arbiter.sv
verilog/target_xfer_fsm.sv
verilog/ccc_handler.sv
verilog/i3c_target_top.sv
verif/tb_clock_gen.sv
verif/tb_i3c_target.sv

//--- run.sh
#!/bin/sh
# Builds and runs the I3C target testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f files.f \
  --top-module tb_i3c_target -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/sim_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation run failed with status $status"
  exit "$status"
fi
exit 0

//--- verif/tb_clock_gen.sv
// Free-running 20 ns clock with reset released on a rising edge after ResetCycles cycles
module tb_clock_gen #(
  parameter int ResetCycles = 10
) (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

//--- verif/tb_i3c_target.sv
// Bus model runs SCL at 16 clocks per bit and the run stops at the first mismatch
module tb_i3c_target;
  timeunit 1ns;
  timeprecision 1ps;
  import i3c_target_pkg::*;

  typedef enum logic [1:0] {
    KindWrite,
    KindRead,
    KindCcc
  } kind_e;

  localparam addr_t StaticAddr = 7'h2A;
  localparam int    WaitLimit  = 200;

  logic  clk_i;
  logic  rst_ni;
  logic  scl           = 1'b1;
  logic  sda_m         = 1'b1;
  logic  sda_bus;
  logic  rx_ready_i    = 1'b1;
  logic  tx_valid_i    = 1'b0;
  byte_t tx_data_i     = '0;
  addr_t static_addr_i = StaticAddr;
  logic  sda_o;
  logic  rx_valid_o;
  logic  tx_ready_o;
  logic  dyn_addr_valid_o;
  logic  parity_err_o;
  logic  rx_overflow_o;
  logic  bus_start_o;
  logic  bus_stop_o;
  byte_t rx_data_o;
  addr_t dyn_addr_o;
  int    seed = 5691;

  // Transaction table, one entry per row and four data bytes per row in data_pool
  string row_name[$];
  kind_e row_kind[$];
  addr_t row_addr[$];
  byte_t data_pool[$];
  int    row_cnt[$];
  int    row_bad[$];
  logic  row_hold[$];
  logic  row_ack[$];
  logic  row_par[$];
  logic  row_ovf[$];
  logic  row_dav[$];

  byte_t rx_got[$];
  byte_t tx_src[$];

  // Open-drain bus
  assign sda_bus = sda_m & sda_o;

  tb_clock_gen tb_clock_gen_inst (
    .clk_o (clk_i),
    .rst_no(rst_ni)
  );

  i3c_target_top #(
    .SyncStages(2)
  ) i3c_target_top_inst (
    .clk_i,
    .rst_ni,
    .scl_i    (scl),
    .sda_i    (sda_bus),
    .rx_ready_i,
    .tx_valid_i,
    .tx_data_i,
    .static_addr_i,
    .sda_o,
    .rx_valid_o,
    .tx_ready_o,
    .dyn_addr_valid_o,
    .parity_err_o,
    .rx_overflow_o,
    .bus_start_o,
    .bus_stop_o,
    .rx_data_o,
    .dyn_addr_o
  );

  // RX sink
  always @(posedge clk_i) begin
    if (rx_valid_o && rx_ready_i) begin
      rx_got.push_back(rx_data_o);
    end
  end

  // TX source advances on each taken byte
  always @(posedge clk_i) begin
    if (tx_ready_o && tx_src.size() != 0) begin
      void'(tx_src.pop_front());
    end
    tx_valid_i <= (tx_src.size() != 0);
    tx_data_i  <= (tx_src.size() != 0) ? tx_src[0] : 8'h00;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_byte(input string name, input byte_t exp, input byte_t act);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED %s expected %b actual %b", name, exp, act));
    end
  endtask

  function automatic byte_t next_byte();
    return byte_t'($random(seed));
  endfunction

  task automatic add_row(input string name, input kind_e kind, input addr_t addr,
                         input byte_t d0, input byte_t d1, input byte_t d2, input byte_t d3,
                         input int cnt, input int bad, input logic hold, input logic ack,
                         input logic par, input logic ovf, input logic dav);
    row_name.push_back(name);
    row_kind.push_back(kind);
    row_addr.push_back(addr);
    data_pool.push_back(d0);
    data_pool.push_back(d1);
    data_pool.push_back(d2);
    data_pool.push_back(d3);
    row_cnt.push_back(cnt);
    row_bad.push_back(bad);
    row_hold.push_back(hold);
    row_ack.push_back(ack);
    row_par.push_back(par);
    row_ovf.push_back(ovf);
    row_dav.push_back(dav);
  endtask

  // One SCL period, SDA set in the middle of the low phase and sampled mid high
  task automatic clock_bit(input logic drive, output logic seen);
    repeat (4) @(posedge clk_i);
    sda_m <= drive;
    repeat (4) @(posedge clk_i);
    scl <= 1'b1;
    repeat (4) @(posedge clk_i);
    seen = sda_bus;
    repeat (4) @(posedge clk_i);
    scl <= 1'b0;
  endtask

  task automatic send_byte(input byte_t b);
    byte_t sh;
    logic  seen;
    sh = b;
    for (int k = 0; k < 8; k++) begin
      clock_bit(sh[7], seen);
      sh = {sh[6:0], 1'b0};
    end
  endtask

  task automatic read_byte(output byte_t b);
    logic seen;
    b = '0;
    for (int k = 0; k < 8; k++) begin
      clock_bit(1'b1, seen);
      b = {b[6:0], seen};
    end
  endtask

  task automatic start_cond();
    int n;
    n = 0;
    @(posedge clk_i);
    sda_m <= 1'b0;
    do begin
      @(posedge clk_i);
      n++;
      if (n > WaitLimit) abort_run("Timeout waiting for the DUT to detect START");
    end while (!bus_start_o);
    repeat (4) @(posedge clk_i);
    scl <= 1'b0;
  endtask

  task automatic stop_cond();
    int n;
    n = 0;
    repeat (4) @(posedge clk_i);
    sda_m <= 1'b0;
    repeat (4) @(posedge clk_i);
    scl <= 1'b1;
    repeat (8) @(posedge clk_i);
    sda_m <= 1'b1;
    do begin
      @(posedge clk_i);
      n++;
      if (n > WaitLimit) abort_run("Timeout waiting for the DUT to detect STOP");
    end while (!bus_stop_o);
    repeat (8) @(posedge clk_i);
  endtask

  task automatic apply_row(input int i);
    string name;
    kind_e kind;
    byte_t b;
    byte_t got;
    logic  seen;
    int    cnt;
    int    n;
    byte_t exp_q[$];
    name = row_name[i];
    kind = row_kind[i];
    cnt  = row_cnt[i];
    @(negedge clk_i);
    rx_got.delete();
    tx_src.delete();
    if (kind == KindRead) begin
      for (int j = 0; j < cnt; j++) tx_src.push_back(data_pool[4*i + j]);
    end
    @(posedge clk_i);
    rx_ready_i <= !row_hold[i];
    repeat (4) @(posedge clk_i);
    start_cond();
    send_byte({row_addr[i], kind == KindRead});
    clock_bit(1'b1, seen);
    // ACK pulls SDA low
    check_flag({name, " address ack"}, !row_ack[i], seen);
    if (row_ack[i]) begin
      for (int j = 0; j < cnt; j++) begin
        b = data_pool[4*i + j];
        if (kind == KindRead) begin
          read_byte(got);
          check_byte({name, " read data"}, b, got);
          clock_bit(1'b1, seen);
          check_flag({name, " read T-bit"}, j < cnt - 1, seen);
        end else begin
          send_byte(b);
          // Odd parity over byte and T-bit
          clock_bit((j == row_bad[i]) ? ^b : ~^b, seen);
          if (kind == KindWrite && j != row_bad[i] && (j == 0 || !row_hold[i])) begin
            exp_q.push_back(b);
          end
        end
      end
    end
    stop_cond();
    check_flag({name, " parity_err_o"}, row_par[i], parity_err_o);
    check_flag({name, " rx_overflow_o"}, row_ovf[i], rx_overflow_o);
    if (row_hold[i]) begin
      @(posedge clk_i);
      rx_ready_i <= 1'b1;
    end
    n = 0;
    while (rx_got.size() < exp_q.size()) begin
      @(posedge clk_i);
      n++;
      if (n > WaitLimit) abort_run({name, ": timeout waiting for bytes on the RX stream"});
    end
    repeat (20) @(posedge clk_i);
    if (rx_got.size() != exp_q.size()) begin
      abort_run($sformatf("%s: RX stream gave %0d bytes where %0d were expected",
                          name, rx_got.size(), exp_q.size()));
    end
    for (int j = 0; j < exp_q.size(); j++) begin
      check_byte({name, " rx data"}, exp_q[j], rx_got[j]);
    end
    check_flag({name, " dyn_addr_valid_o"}, row_dav[i], dyn_addr_valid_o);
    if (row_dav[i]) begin
      check_addr({name, " dyn_addr_o"}, StaticAddr, dyn_addr_o);
    end
  endtask

  initial begin
    int n;
    add_row("nack_before_ccc", KindWrite, StaticAddr, 8'h11, 8'h00, 8'h00, 8'h00,
            1, -1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    add_row("setaasa", KindCcc, BroadcastAddr, CccSetaasa, 8'h00, 8'h00, 8'h00,
            1, -1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
    add_row("write_random", KindWrite, StaticAddr, next_byte(), next_byte(), next_byte(),
            next_byte(), 4, -1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
    add_row("read_stream", KindRead, StaticAddr, 8'hA5, 8'h3C, 8'h0F, 8'h00,
            3, -1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
    add_row("write_bad_parity", KindWrite, StaticAddr, next_byte(), next_byte(), next_byte(),
            8'h00, 3, 1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1);
    add_row("write_overflow", KindWrite, StaticAddr, next_byte(), next_byte(), 8'h00, 8'h00,
            2, -1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1);
    add_row("rstdaa", KindCcc, BroadcastAddr, CccRstdaa, 8'h00, 8'h00, 8'h00,
            1, -1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    add_row("nack_after_rstdaa", KindWrite, StaticAddr, 8'h22, 8'h00, 8'h00, 8'h00,
            1, -1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    n = 0;
    while (rst_ni !== 1'b1) begin
      @(posedge clk_i);
      n++;
      if (n > WaitLimit) abort_run("Timeout waiting for reset release");
    end
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    check_flag("reset sda_o", 1'b1, sda_o);
    check_flag("reset rx_valid_o", 1'b0, rx_valid_o);
    check_flag("reset tx_ready_o", 1'b0, tx_ready_o);
    check_flag("reset dyn_addr_valid_o", 1'b0, dyn_addr_valid_o);
    check_flag("reset parity_err_o", 1'b0, parity_err_o);
    check_flag("reset rx_overflow_o", 1'b0, rx_overflow_o);
    check_flag("reset bus_start_o", 1'b0, bus_start_o);
    check_flag("reset bus_stop_o", 1'b0, bus_stop_o);
    for (int i = 0; i < row_name.size(); i++) begin
      apply_row(i);
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

//--- verilog/bus_arbiter.sv
// Owner changes only on ccc_begin and ccc_done so requests must not be open across a switch
module bus_arbiter (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  ccc_begin_i,
  input  logic                  ccc_done_i,
  input  logic                  xfer_rx_req_bit_i,
  input  logic                  xfer_rx_req_byte_i,
  input  logic                  xfer_tx_req_bit_i,
  input  logic                  xfer_tx_req_byte_i,
  input  i3c_target_pkg::byte_t xfer_tx_value_i,
  output logic                  xfer_rx_done_o,
  output logic                  xfer_tx_done_o,
  output i3c_target_pkg::byte_t xfer_rx_data_o,
  input  logic                  ccc_rx_req_bit_i,
  input  logic                  ccc_rx_req_byte_i,
  input  logic                  ccc_tx_req_bit_i,
  input  logic                  ccc_tx_req_byte_i,
  input  i3c_target_pkg::byte_t ccc_tx_value_i,
  output logic                  ccc_rx_done_o,
  output logic                  ccc_tx_done_o,
  output i3c_target_pkg::byte_t ccc_rx_data_o,
  input  logic                  rx_done_i,
  input  logic                  tx_done_i,
  input  i3c_target_pkg::byte_t rx_data_i,
  output logic                  rx_req_bit_o,
  output logic                  rx_req_byte_o,
  output logic                  tx_req_bit_o,
  output logic                  tx_req_byte_o,
  output i3c_target_pkg::byte_t tx_value_o
);
  import i3c_target_pkg::*;

  peer_sel_e sel_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q <= PeerXfer;
    end else if (sel_q == PeerXfer && ccc_begin_i) begin
      sel_q <= PeerCcc;
    end else if (sel_q == PeerCcc && ccc_done_i) begin
      sel_q <= PeerXfer;
    end
  end

  always_comb begin
    xfer_rx_done_o = 1'b0;
    xfer_tx_done_o = 1'b0;
    xfer_rx_data_o = '0;
    ccc_rx_done_o  = 1'b0;
    ccc_tx_done_o  = 1'b0;
    ccc_rx_data_o  = '0;
    if (sel_q == PeerXfer) begin
      rx_req_bit_o   = xfer_rx_req_bit_i;
      rx_req_byte_o  = xfer_rx_req_byte_i;
      tx_req_bit_o   = xfer_tx_req_bit_i;
      tx_req_byte_o  = xfer_tx_req_byte_i;
      tx_value_o     = xfer_tx_value_i;
      xfer_rx_done_o = rx_done_i;
      xfer_tx_done_o = tx_done_i;
      xfer_rx_data_o = rx_data_i;
    end else begin
      rx_req_bit_o  = ccc_rx_req_bit_i;
      rx_req_byte_o = ccc_rx_req_byte_i;
      tx_req_bit_o  = ccc_tx_req_bit_i;
      tx_req_byte_o = ccc_tx_req_byte_i;
      tx_value_o    = ccc_tx_value_i;
      ccc_rx_done_o = rx_done_i;
      ccc_tx_done_o = tx_done_i;
      ccc_rx_data_o = rx_data_i;
    end
  end

endmodule

//--- verilog/bus_monitor.sv
// Pins must be stable for a few clocks and SCL must run well below clk_i/4
module bus_monitor #(
  parameter int unsigned SyncStages = 2
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic scl_i,
  input  logic sda_i,
  output logic sda_sync_o,
  output logic scl_rise_o,
  output logic scl_fall_o,
  output logic start_det_o,
  output logic stop_det_o
);

  logic [SyncStages-1:0] scl_sync_q;
  logic [SyncStages-1:0] sda_sync_q;
  logic scl_s;
  logic sda_s;
  logic scl_prev_q;
  logic sda_prev_q;

  assign scl_s = scl_sync_q[SyncStages-1];
  assign sda_s = sda_sync_q[SyncStages-1];
  assign sda_sync_o = sda_s;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // Idle bus is high
      scl_sync_q  <= '1;
      sda_sync_q  <= '1;
      scl_prev_q  <= 1'b1;
      sda_prev_q  <= 1'b1;
      scl_rise_o  <= 1'b0;
      scl_fall_o  <= 1'b0;
      start_det_o <= 1'b0;
      stop_det_o  <= 1'b0;
    end else begin
      scl_sync_q  <= {scl_sync_q[SyncStages-2:0], scl_i};
      sda_sync_q  <= {sda_sync_q[SyncStages-2:0], sda_i};
      scl_prev_q  <= scl_s;
      sda_prev_q  <= sda_s;
      scl_rise_o  <= scl_s & ~scl_prev_q;
      scl_fall_o  <= ~scl_s & scl_prev_q;
      // SDA edges while SCL stays high
      start_det_o <= scl_s & scl_prev_q & ~sda_s & sda_prev_q;
      stop_det_o  <= scl_s & scl_prev_q & sda_s & ~sda_prev_q;
    end
  end

endmodule

//--- verilog/bus_rx_flow.sv
// A new request restarts any open one and a bit request returns its bit in the LSB
module bus_rx_flow (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  sda_i,
  input  logic                  scl_rise_i,
  input  logic                  req_bit_i,
  input  logic                  req_byte_i,
  output logic                  done_o,
  output i3c_target_pkg::byte_t data_o
);
  import i3c_target_pkg::*;

  byte_t      shift_q;
  logic [2:0] cnt_q;
  logic       busy_q;
  logic       byte_mode_q;
  logic       sample;

  assign sample = busy_q & scl_rise_i;
  assign data_o = shift_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      byte_mode_q <= 1'b0;
      cnt_q       <= '0;
      done_o      <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (req_bit_i || req_byte_i) begin
        busy_q      <= 1'b1;
        byte_mode_q <= req_byte_i;
        cnt_q       <= '0;
      end else if (sample) begin
        cnt_q <= cnt_q + 3'd1;
        if (cnt_q == (byte_mode_q ? 3'd7 : 3'd0)) begin
          busy_q <= 1'b0;
          done_o <= 1'b1;
        end
      end
    end
  end

  // MSB first
  always_ff @(posedge clk_i) begin
    if (req_bit_i || req_byte_i) begin
      shift_q <= '0;
    end else if (sample) begin
      shift_q <= {shift_q[6:0], sda_i};
    end
  end

endmodule

//--- verilog/bus_tx_flow.sv
// Open drain only so a one bit releases SDA and the target never checks arbitration
module bus_tx_flow (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  scl_fall_i,
  input  logic                  req_bit_i,
  input  logic                  req_byte_i,
  input  i3c_target_pkg::byte_t value_i,
  output logic                  done_o,
  output logic                  sda_o
);
  import i3c_target_pkg::*;

  byte_t      shift_q;
  byte_t      first;
  logic [3:0] cnt_q;
  logic       busy_q;
  logic       byte_mode_q;
  logic       chain_q;

  // A bit request sends only the LSB
  assign first = req_byte_i ? value_i : {value_i[0], 7'b0};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shift_q     <= '0;
      cnt_q       <= '0;
      busy_q      <= 1'b0;
      byte_mode_q <= 1'b0;
      chain_q     <= 1'b0;
      done_o      <= 1'b0;
      sda_o       <= 1'b1;
    end else begin
      done_o <= 1'b0;
      if (scl_fall_i) begin
        chain_q <= 1'b0;
      end
      if (req_bit_i || req_byte_i) begin
        busy_q      <= 1'b1;
        byte_mode_q <= req_byte_i;
        if (chain_q) begin
          // Back-to-back request starts on the falling edge that ended the last one
          sda_o   <= first[7];
          shift_q <= {first[6:0], 1'b0};
          cnt_q   <= 4'd1;
        end else begin
          shift_q <= first;
          cnt_q   <= '0;
        end
      end else if (busy_q && scl_fall_i) begin
        if (cnt_q == (byte_mode_q ? 4'd8 : 4'd1)) begin
          busy_q  <= 1'b0;
          done_o  <= 1'b1;
          chain_q <= 1'b1;
          sda_o   <= 1'b1;
        end else begin
          sda_o   <= shift_q[7];
          shift_q <= {shift_q[6:0], 1'b0};
          cnt_q   <= cnt_q + 4'd1;
        end
      end
    end
  end

endmodule

//--- verilog/ccc_handler.sv
// Broadcast RSTDAA and SETAASA only and an aborted CCC waits for the next received byte
module ccc_handler (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  ccc_begin_i,
  input  logic                  rx_done_i,
  input  i3c_target_pkg::byte_t rx_data_i,
  input  i3c_target_pkg::addr_t static_addr_i,
  output logic                  rx_req_bit_o,
  output logic                  rx_req_byte_o,
  output logic                  ccc_done_o,
  output logic                  dyn_addr_valid_o,
  output i3c_target_pkg::addr_t dyn_addr_o
);
  import i3c_target_pkg::*;

  typedef enum logic [1:0] {
    CccIdle,
    CccCode,
    CccTbit
  } ccc_state_e;

  ccc_state_e state_q;
  byte_t      code_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q          <= CccIdle;
      code_q           <= '0;
      rx_req_bit_o     <= 1'b0;
      rx_req_byte_o    <= 1'b0;
      ccc_done_o       <= 1'b0;
      dyn_addr_valid_o <= 1'b0;
      dyn_addr_o       <= '0;
    end else begin
      rx_req_bit_o  <= 1'b0;
      rx_req_byte_o <= 1'b0;
      ccc_done_o    <= 1'b0;
      unique case (state_q)
        CccIdle: begin
          if (ccc_begin_i) begin
            rx_req_byte_o <= 1'b1;
            state_q       <= CccCode;
          end
        end
        CccCode: begin
          if (rx_done_i) begin
            code_q       <= rx_data_i;
            rx_req_bit_o <= 1'b1;
            state_q      <= CccTbit;
          end
        end
        CccTbit: begin
          if (rx_done_i) begin
            ccc_done_o <= 1'b1;
            state_q    <= CccIdle;
            // Code is acted on only with good parity
            if (rx_data_i[0] == ~^code_q) begin
              if (code_q == CccSetaasa) begin
                dyn_addr_o       <= static_addr_i;
                dyn_addr_valid_o <= 1'b1;
              end else if (code_q == CccRstdaa) begin
                dyn_addr_valid_o <= 1'b0;
              end
            end
          end
        end
        default: state_q <= CccIdle;
      endcase
    end
  end

endmodule

//--- verilog/i3c_target_pkg.sv
// Covers SDR mode only with 7-bit addresses and two broadcast CCC codes
package i3c_target_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [6:0] addr_t;

  typedef enum logic {
    PeerXfer,
    PeerCcc
  } peer_sel_e;

  typedef enum logic [3:0] {
    Idle,
    Addr,
    AddrAck,
    Nack,
    WrByte,
    WrTbit,
    RdByte,
    RdTbit,
    CccWait
  } xfer_state_e;

  localparam addr_t BroadcastAddr = 7'h7E;

  // Broadcast CCC codes
  localparam byte_t CccRstdaa  = 8'h06;
  localparam byte_t CccSetaasa = 8'h29;

endpackage

//--- verilog/i3c_target_top.sv
// SCL is input only and sda_o must be wired open drain with the bus SDA level on sda_i
module i3c_target_top #(
  parameter int unsigned SyncStages = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  scl_i,
  input  logic                  sda_i,
  input  logic                  rx_ready_i,
  input  logic                  tx_valid_i,
  input  i3c_target_pkg::byte_t tx_data_i,
  input  i3c_target_pkg::addr_t static_addr_i,
  output logic                  sda_o,
  output logic                  rx_valid_o,
  output logic                  tx_ready_o,
  output logic                  dyn_addr_valid_o,
  output logic                  parity_err_o,
  output logic                  rx_overflow_o,
  output logic                  bus_start_o,
  output logic                  bus_stop_o,
  output i3c_target_pkg::byte_t rx_data_o,
  output i3c_target_pkg::addr_t dyn_addr_o
);
  import i3c_target_pkg::*;

  logic  sda_sync;
  logic  scl_rise;
  logic  scl_fall;
  logic  ccc_begin;
  logic  ccc_done;

  // Engine side of the arbiter
  logic  rx_req_bit;
  logic  rx_req_byte;
  logic  rx_done;
  logic  tx_req_bit;
  logic  tx_req_byte;
  logic  tx_done;
  byte_t rx_data;
  byte_t tx_value;

  // Private transfer peer
  logic  xfer_rx_req_bit;
  logic  xfer_rx_req_byte;
  logic  xfer_tx_req_bit;
  logic  xfer_tx_req_byte;
  logic  xfer_rx_done;
  logic  xfer_tx_done;
  byte_t xfer_rx_data;
  byte_t xfer_tx_value;

  // CCC peer only receives
  logic  ccc_rx_req_bit;
  logic  ccc_rx_req_byte;
  logic  ccc_rx_done;
  byte_t ccc_rx_data;

  bus_monitor #(
    .SyncStages(SyncStages)
  ) bus_monitor_inst (
    .clk_i,
    .rst_ni,
    .scl_i,
    .sda_i,
    .sda_sync_o (sda_sync),
    .scl_rise_o (scl_rise),
    .scl_fall_o (scl_fall),
    .start_det_o(bus_start_o),
    .stop_det_o (bus_stop_o)
  );

  bus_rx_flow bus_rx_flow_inst (
    .clk_i,
    .rst_ni,
    .sda_i     (sda_sync),
    .scl_rise_i(scl_rise),
    .req_bit_i (rx_req_bit),
    .req_byte_i(rx_req_byte),
    .done_o    (rx_done),
    .data_o    (rx_data)
  );

  bus_tx_flow bus_tx_flow_inst (
    .clk_i,
    .rst_ni,
    .scl_fall_i(scl_fall),
    .req_bit_i (tx_req_bit),
    .req_byte_i(tx_req_byte),
    .value_i   (tx_value),
    .done_o    (tx_done),
    .sda_o
  );

  bus_arbiter bus_arbiter_inst (
    .clk_i,
    .rst_ni,
    .ccc_begin_i       (ccc_begin),
    .ccc_done_i        (ccc_done),
    .xfer_rx_req_bit_i (xfer_rx_req_bit),
    .xfer_rx_req_byte_i(xfer_rx_req_byte),
    .xfer_tx_req_bit_i (xfer_tx_req_bit),
    .xfer_tx_req_byte_i(xfer_tx_req_byte),
    .xfer_tx_value_i   (xfer_tx_value),
    .xfer_rx_done_o    (xfer_rx_done),
    .xfer_tx_done_o    (xfer_tx_done),
    .xfer_rx_data_o    (xfer_rx_data),
    .ccc_rx_req_bit_i  (ccc_rx_req_bit),
    .ccc_rx_req_byte_i (ccc_rx_req_byte),
    .ccc_tx_req_bit_i  (1'b0),
    .ccc_tx_req_byte_i (1'b0),
    .ccc_tx_value_i    ('0),
    .ccc_rx_done_o     (ccc_rx_done),
    .ccc_tx_done_o     (),
    .ccc_rx_data_o     (ccc_rx_data),
    .rx_done_i         (rx_done),
    .tx_done_i         (tx_done),
    .rx_data_i         (rx_data),
    .rx_req_bit_o      (rx_req_bit),
    .rx_req_byte_o     (rx_req_byte),
    .tx_req_bit_o      (tx_req_bit),
    .tx_req_byte_o     (tx_req_byte),
    .tx_value_o        (tx_value)
  );

  target_xfer_fsm target_xfer_fsm_inst (
    .clk_i,
    .rst_ni,
    .start_det_i     (bus_start_o),
    .stop_det_i      (bus_stop_o),
    .rx_done_i       (xfer_rx_done),
    .tx_done_i       (xfer_tx_done),
    .dyn_addr_valid_i(dyn_addr_valid_o),
    .rx_ready_i,
    .tx_valid_i,
    .rx_data_i       (xfer_rx_data),
    .tx_data_i,
    .dyn_addr_i      (dyn_addr_o),
    .rx_req_bit_o    (xfer_rx_req_bit),
    .rx_req_byte_o   (xfer_rx_req_byte),
    .tx_req_bit_o    (xfer_tx_req_bit),
    .tx_req_byte_o   (xfer_tx_req_byte),
    .ccc_begin_o     (ccc_begin),
    .rx_valid_o,
    .tx_ready_o,
    .parity_err_o,
    .rx_overflow_o,
    .tx_value_o      (xfer_tx_value),
    .rx_data_o
  );

  ccc_handler ccc_handler_inst (
    .clk_i,
    .rst_ni,
    .ccc_begin_i  (ccc_begin),
    .rx_done_i    (ccc_rx_done),
    .rx_data_i    (ccc_rx_data),
    .static_addr_i,
    .rx_req_bit_o (ccc_rx_req_bit),
    .rx_req_byte_o(ccc_rx_req_byte),
    .ccc_done_o   (ccc_done),
    .dyn_addr_valid_o,
    .dyn_addr_o
  );

endmodule

//--- verilog/target_xfer_fsm.sv
// Repeated START is not handled and the RX buffer holds one byte with no bus back-pressure
module target_xfer_fsm (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  start_det_i,
  input  logic                  stop_det_i,
  input  logic                  rx_done_i,
  input  logic                  tx_done_i,
  input  logic                  dyn_addr_valid_i,
  input  logic                  rx_ready_i,
  input  logic                  tx_valid_i,
  input  i3c_target_pkg::byte_t rx_data_i,
  input  i3c_target_pkg::byte_t tx_data_i,
  input  i3c_target_pkg::addr_t dyn_addr_i,
  output logic                  rx_req_bit_o,
  output logic                  rx_req_byte_o,
  output logic                  tx_req_bit_o,
  output logic                  tx_req_byte_o,
  output logic                  ccc_begin_o,
  output logic                  rx_valid_o,
  output logic                  tx_ready_o,
  output logic                  parity_err_o,
  output logic                  rx_overflow_o,
  output i3c_target_pkg::byte_t tx_value_o,
  output i3c_target_pkg::byte_t rx_data_o
);
  import i3c_target_pkg::*;

  xfer_state_e state_q;
  byte_t       data_q;
  addr_t       addr;
  logic        rnw;
  logic        is_bcast;
  logic        dyn_hit;
  logic        ack;
  logic        rnw_q;
  logic        bcast_q;

  assign addr     = rx_data_i[7:1];
  assign rnw      = rx_data_i[0];
  assign is_bcast = (addr == BroadcastAddr);
  assign dyn_hit  = dyn_addr_valid_i && (addr == dyn_addr_i);
  // Reads are only ACKed with a byte ready to send
  assign ack      = (is_bcast && !rnw) || (dyn_hit && (!rnw || tx_valid_i));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= Idle;
      data_q        <= '0;
      rnw_q         <= 1'b0;
      bcast_q       <= 1'b0;
      rx_req_bit_o  <= 1'b0;
      rx_req_byte_o <= 1'b0;
      tx_req_bit_o  <= 1'b0;
      tx_req_byte_o <= 1'b0;
      ccc_begin_o   <= 1'b0;
      rx_valid_o    <= 1'b0;
      tx_ready_o    <= 1'b0;
      parity_err_o  <= 1'b0;
      rx_overflow_o <= 1'b0;
      tx_value_o    <= '0;
      rx_data_o     <= '0;
    end else begin
      rx_req_bit_o  <= 1'b0;
      rx_req_byte_o <= 1'b0;
      tx_req_bit_o  <= 1'b0;
      tx_req_byte_o <= 1'b0;
      ccc_begin_o   <= 1'b0;
      tx_ready_o    <= 1'b0;
      if (rx_valid_o && rx_ready_i) begin
        rx_valid_o <= 1'b0;
      end
      if (start_det_i) begin
        parity_err_o  <= 1'b0;
        rx_overflow_o <= 1'b0;
      end
      if (stop_det_i) begin
        state_q <= Idle;
      end else begin
        unique case (state_q)
          Idle: begin
            if (start_det_i) begin
              rx_req_byte_o <= 1'b1;
              state_q       <= Addr;
            end
          end
          Addr: begin
            if (rx_done_i) begin
              rnw_q   <= rnw;
              bcast_q <= is_bcast;
              if (ack) begin
                tx_req_bit_o <= 1'b1;
                tx_value_o   <= '0;
                state_q      <= AddrAck;
              end else begin
                state_q <= Nack;
              end
            end
          end
          AddrAck: begin
            if (tx_done_i) begin
              if (bcast_q) begin
                ccc_begin_o <= 1'b1;
                state_q     <= CccWait;
              end else if (rnw_q) begin
                tx_req_byte_o <= 1'b1;
                tx_value_o    <= tx_data_i;
                tx_ready_o    <= 1'b1;
                state_q       <= RdByte;
              end else begin
                rx_req_byte_o <= 1'b1;
                state_q       <= WrByte;
              end
            end
          end
          WrByte: begin
            if (rx_done_i) begin
              data_q       <= rx_data_i;
              rx_req_bit_o <= 1'b1;
              state_q      <= WrTbit;
            end
          end
          WrTbit: begin
            if (rx_done_i) begin
              // Odd parity over data and T-bit
              if (rx_data_i[0] != ~^data_q) begin
                parity_err_o <= 1'b1;
              end else if (rx_valid_o && !rx_ready_i) begin
                rx_overflow_o <= 1'b1;
              end else begin
                rx_valid_o <= 1'b1;
                rx_data_o  <= data_q;
              end
              rx_req_byte_o <= 1'b1;
              state_q       <= WrByte;
            end
          end
          RdByte: begin
            if (tx_done_i) begin
              // T-bit high while more data follows
              tx_req_bit_o <= 1'b1;
              tx_value_o   <= {7'b0, tx_valid_i};
              state_q      <= RdTbit;
            end
          end
          RdTbit: begin
            if (tx_done_i) begin
              if (tx_value_o[0]) begin
                tx_req_byte_o <= 1'b1;
                tx_value_o    <= tx_data_i;
                tx_ready_o    <= 1'b1;
                state_q       <= RdByte;
              end else begin
                state_q <= Nack;
              end
            end
          end
          // Both hold until STOP
          Nack, CccWait: ;
          default: state_q <= Idle;
        endcase
      end
    end
  end

endmodule
